// File: logic/decodeStage.sv
`default_nettype none

module decodeStage import mipsPkg::*; (
    input  wire         clk,
    input  wire         rst_i,
    input  wire         stall_i,
    input  wire word_t  pcD_i,
    input  wire instr_u instrD_i,
    input  wire wbBus_s fwdE_i,
    input  wire wbBus_s fwdW_i,
    output execIn_s     execIn_o
);

    word_t   regs [1:31];
    aluOp_e  aluOp;
    logic    useImm;      // I-type, destination is rt
    logic    sextImm;
    logic    writesReg;
    logic    regWrite;
    logic    rfWe;
    regIdx_t dst;
    word_t   immExt;
    word_t   opA;
    word_t   opB;

    function automatic word_t pickOperand(regIdx_t idx, word_t rfVal);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (fwdE_i.we && fwdE_i.idx == idx) begin
            val = fwdE_i.data;    // youngest result wins
        end else if (fwdW_i.we && fwdW_i.idx == idx) begin
            val = fwdW_i.data;
        end else begin
            val = rfVal;
        end
        return val;
    endfunction

    always_comb begin
        aluOp   = AluNone;
        useImm  = 1'b0;
        sextImm = 1'b0;
        if (instrD_i.r.opcode == 6'h00) begin
            case (instrD_i.r.funct)
                6'h21: aluOp = AluAdd;
                6'h23: aluOp = AluSub;
                6'h24: aluOp = AluAnd;
                6'h25: aluOp = AluOr;
                6'h26: aluOp = AluXor;
                6'h2A: aluOp = AluSlt;
                6'h00: aluOp = AluSll;      // also the all-zero nop
                6'h10: aluOp = AluMfhi;
                6'h12: aluOp = AluMflo;
                6'h19: aluOp = AluMultu;
                6'h1B: aluOp = AluDivu;
                default: aluOp = AluNone;
            endcase
        end else begin
            useImm = 1'b1;
            case (instrD_i.i.opcode)
                6'h09: begin
                    aluOp   = AluAdd;
                    sextImm = 1'b1;
                end
                6'h0D: aluOp = AluOr;
                6'h0F: aluOp = AluLui;
                default: aluOp = AluNone;
            endcase
        end
    end

    assign writesReg = (aluOp != AluNone) && (aluOp != AluMultu) && (aluOp != AluDivu);
    assign dst       = useImm ? instrD_i.i.rt : instrD_i.r.rd;
    assign regWrite  = writesReg && (dst != '0);    // $0 writes vanish here
    assign immExt    = sextImm ? {{(Xlen-16){instrD_i.i.imm[15]}}, instrD_i.i.imm}
                               : {{(Xlen-16){1'b0}}, instrD_i.i.imm};

    always_comb begin
        opA = pickOperand(instrD_i.r.rs, regs[instrD_i.r.rs]);
        opB = useImm ? immExt : pickOperand(instrD_i.r.rt, regs[instrD_i.r.rt]);
    end

    assign execIn_o = '{pc: pcD_i, opA: opA, opB: opB, shamt: instrD_i.r.shamt,
                        aluOp: aluOp, regWrite: regWrite, dst: dst};

    // register file, written from the writeback slot
    assign rfWe = fwdW_i.we && !stall_i && (fwdW_i.idx != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (rfWe) begin
            regs[fwdW_i.idx] <= fwdW_i.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`default_nettype none

module executeStage import mipsPkg::*; (
    input  wire          clk,
    input  wire          rst_i,
    input  wire          stall_i,
    input  wire execIn_s execIn_i,
    input  wire word_t   hi_i,
    input  wire word_t   lo_i,
    output logic         mdStart_o,
    output aluOp_e       mdOp_o,
    output word_t        mdA_o,
    output word_t        mdB_o,
    output wbBus_s       fwdE_o,
    output wbBus_s       fwdW_o,
    output wbDebug_s     debugWb_o
);

    execIn_s exQ;
    wbBus_s  wbQ;
    word_t   pcWQ;
    word_t   aluRes;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exQ.aluOp    <= AluNone;
            exQ.regWrite <= 1'b0;
        end else if (!stall_i) begin
            exQ <= execIn_i;
        end
    end

    always_comb begin
        case (exQ.aluOp)
            AluAdd:  aluRes = exQ.opA + exQ.opB;
            AluSub:  aluRes = exQ.opA - exQ.opB;
            AluAnd:  aluRes = exQ.opA & exQ.opB;
            AluOr:   aluRes = exQ.opA | exQ.opB;
            AluXor:  aluRes = exQ.opA ^ exQ.opB;
            AluSlt:  aluRes = ($signed(exQ.opA) < $signed(exQ.opB)) ? Xlen'(1) : '0;
            AluSll:  aluRes = exQ.opB << exQ.shamt;
            AluLui:  aluRes = {exQ.opB[15:0], 16'h0000};
            AluMfhi: aluRes = hi_i;
            AluMflo: aluRes = lo_i;
            default: aluRes = '0;
        endcase
    end

    // one pulse, the op leaves execute in that same cycle
    assign mdStart_o = ((exQ.aluOp == AluMultu) || (exQ.aluOp == AluDivu)) && !stall_i;
    assign mdOp_o    = exQ.aluOp;
    assign mdA_o     = exQ.opA;
    assign mdB_o     = exQ.opB;

    assign fwdE_o = '{we: exQ.regWrite, idx: exQ.dst, data: aluRes};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wbQ.we <= 1'b0;
        end else if (stall_i) begin
            wbQ.we <= 1'b0;      // bubble into writeback
        end else begin
            wbQ <= fwdE_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcWQ <= exQ.pc;
        end
    end

    assign fwdW_o    = wbQ;
    assign debugWb_o = '{pc: pcWQ, wen: {4{wbQ.we}}, wnum: wbQ.idx, wdata: wbQ.data};

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
`default_nettype none

module fetchStage import mipsPkg::*; #(
    parameter word_t PcReset = PcResetDefault
) (
    input  wire        clk,
    input  wire        rst_i,
    input  wire        stall_i,
    input  wire word_t instrF_i,
    output word_t      pcF_o,
    output logic       instEnF_o,
    output word_t      pcD_o,
    output instr_u     instrD_o
);

    word_t  pcQ;
    word_t  pcDQ;
    logic   fetchOnQ;    // first fetch one cycle after reset
    logic   validQ;      // decode slot holds a real fetch

    assign instEnF_o = fetchOnQ & ~stall_i;
    assign pcF_o     = pcQ;
    assign pcD_o     = pcDQ;

    // rom word stays put while the enable is low
    assign instrD_o  = validQ ? instrF_i : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pcQ      <= PcReset;
            fetchOnQ <= 1'b0;
            validQ   <= 1'b0;
        end else begin
            fetchOnQ <= 1'b1;
            if (!stall_i) begin
                validQ <= instEnF_o;
                if (instEnF_o) begin
                    pcQ <= pcQ + Xlen'(4);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcDQ <= pcQ;    // pc of the word the rom returns next
        end
    end

endmodule

`default_nettype wire

// File: logic/iterCounter.sv
`default_nettype none

module iterCounter import mipsPkg::*; #(
    parameter int Iters = MulDivIters
) (
    input  wire  clk,
    input  wire  rst_i,
    input  wire  load_i,
    input  wire  step_i,
    output logic last_o
);

    localparam int CntW = (Iters > 1) ? $clog2(Iters) : 1;

    logic [CntW-1:0] cntQ;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cntQ <= '0;
        end else if (load_i) begin
            cntQ <= CntW'(Iters - 1);
        end else if (step_i && cntQ != '0) begin
            cntQ <= cntQ - 1'b1;
        end
    end

    assign last_o = step_i && (cntQ == '0);   // final iteration

endmodule

`default_nettype wire

// File: logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int Xlen = 32;

    typedef logic [Xlen-1:0] word_t;
    typedef logic [4:0]      regIdx_t;

    // register-register layout
    typedef struct packed {
        logic [5:0] opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_s;

    // immediate layout, rt is the destination here
    typedef struct packed {
        logic [5:0]  opcode;
        regIdx_t     rs;
        regIdx_t     rt;
        logic [15:0] imm;
    } iType_s;

    typedef union packed {
        rType_s r;
        iType_s i;
    } instr_u;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSll,
        AluLui, AluMfhi, AluMflo, AluMultu, AluDivu, AluNone
    } aluOp_e;

    // decode -> execute bundle
    typedef struct packed {
        word_t      pc;
        word_t      opA;
        word_t      opB;
        logic [4:0] shamt;
        aluOp_e     aluOp;
        logic       regWrite;
        regIdx_t    dst;
    } execIn_s;

    typedef struct packed {
        logic    we;
        regIdx_t idx;
        word_t   data;
    } wbBus_s;

    typedef struct packed {
        word_t      pc;
        logic [3:0] wen;    // byte-wide copy of the write enable
        regIdx_t    wnum;
        word_t      wdata;
    } wbDebug_s;

    localparam word_t PcResetDefault = 32'hBFC0_0000;
    localparam int    MulDivIters    = Xlen;

endpackage

`default_nettype wire

// File: logic/mulDivDatapath.sv
`default_nettype none

module mulDivDatapath import mipsPkg::*; (
    input  wire         clk,
    input  wire         rst_i,
    input  wire         load_i,
    input  wire         step_i,
    input  wire         commit_i,
    input  wire aluOp_e op_i,
    input  wire word_t  a_i,
    input  wire word_t  b_i,
    output word_t       hi_o,
    output word_t       lo_o
);

    word_t         accQ;     // partial product / partial remainder
    word_t         shQ;      // multiplier bits out, quotient bits in
    word_t         bQ;       // multiplicand or divisor
    logic          isDivQ;
    word_t         hiQ;
    word_t         loQ;
    logic [Xlen:0] addSum;
    logic [Xlen:0] trial;
    logic [Xlen:0] diff;
    logic          fits;
    word_t         accNext;
    word_t         shNext;

    assign addSum = {1'b0, accQ} + (shQ[0] ? {1'b0, bQ} : '0);
    assign trial  = {accQ, shQ[Xlen-1]};
    assign diff   = trial - {1'b0, bQ};
    assign fits   = (trial >= {1'b0, bQ});

    always_comb begin
        if (isDivQ) begin
            // restoring step, a zero divisor always fits
            accNext = fits ? diff[Xlen-1:0] : trial[Xlen-1:0];
            shNext  = {shQ[Xlen-2:0], fits};
        end else begin
            accNext = addSum[Xlen:1];
            shNext  = {addSum[0], shQ[Xlen-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            accQ <= '0;
            shQ  <= a_i;
            bQ   <= b_i;
        end else if (step_i) begin
            accQ <= accNext;
            shQ  <= shNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            isDivQ <= 1'b0;
            hiQ    <= '0;
            loQ    <= '0;
        end else begin
            if (load_i) begin
                isDivQ <= (op_i == AluDivu);
            end
            if (commit_i) begin
                hiQ <= accQ;    // remainder or upper product
                loQ <= shQ;
            end
        end
    end

    assign hi_o = hiQ;
    assign lo_o = loQ;

endmodule

`default_nettype wire

// File: logic/mulDivFsm.sv
`default_nettype none

module mulDivFsm (
    input  wire  clk,
    input  wire  rst_i,
    input  wire  start_i,
    input  wire  last_i,
    output logic busy_o,
    output logic load_o,
    output logic step_o,
    output logic commit_o
);

    typedef enum logic [1:0] {
        Idle,
        Run,
        Done
    } state_e;

    state_e stateQ;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            stateQ <= Idle;
        end else begin
            case (stateQ)
                Idle: if (start_i) stateQ <= Run;
                Run:  if (last_i) stateQ <= Done;
                default: stateQ <= Idle;    // done lasts one cycle
            endcase
        end
    end

    assign busy_o   = (stateQ != Idle);
    assign load_o   = start_i && (stateQ == Idle);   // grab operands, arm counter
    assign step_o   = (stateQ == Run);
    assign commit_o = (stateQ == Done);

endmodule

`default_nettype wire

// File: logic/pipeCore.sv
`default_nettype none

module pipeCore import mipsPkg::*; #(
    parameter word_t PcReset = PcResetDefault,
    parameter int    Iters   = MulDivIters
) (
    input  wire        clk,
    input  wire        rst_i,
    input  wire word_t instrF_i,
    output word_t      pcF_o,
    output logic       instEnF_o,
    output logic       mulDivBusy_o,
    output wbDebug_s   debugWb_o
);

    word_t   pcD;
    instr_u  instrD;
    execIn_s execIn;
    wbBus_s  fwdE;
    wbBus_s  fwdW;

    // multiply/divide side
    logic    mdStart;
    aluOp_e  mdOp;
    word_t   mdA;
    word_t   mdB;
    word_t   hi;
    word_t   lo;
    logic    mdLoad;
    logic    mdStep;
    logic    mdCommit;
    logic    mdLast;

    fetchStage #(.PcReset(PcReset)) fetch (
        .clk(clk), .rst_i(rst_i), .stall_i(mulDivBusy_o),
        .instrF_i(instrF_i), .pcF_o(pcF_o), .instEnF_o(instEnF_o),
        .pcD_o(pcD), .instrD_o(instrD)
    );

    decodeStage decode (
        .clk(clk), .rst_i(rst_i), .stall_i(mulDivBusy_o),
        .pcD_i(pcD), .instrD_i(instrD),
        .fwdE_i(fwdE), .fwdW_i(fwdW), .execIn_o(execIn)
    );

    executeStage execute (
        .clk(clk), .rst_i(rst_i), .stall_i(mulDivBusy_o),
        .execIn_i(execIn), .hi_i(hi), .lo_i(lo),
        .mdStart_o(mdStart), .mdOp_o(mdOp), .mdA_o(mdA), .mdB_o(mdB),
        .fwdE_o(fwdE), .fwdW_o(fwdW), .debugWb_o(debugWb_o)
    );

    mulDivFsm mdFsm (
        .clk(clk), .rst_i(rst_i), .start_i(mdStart), .last_i(mdLast),
        .busy_o(mulDivBusy_o), .load_o(mdLoad), .step_o(mdStep), .commit_o(mdCommit)
    );

    iterCounter #(.Iters(Iters)) mdCount (
        .clk(clk), .rst_i(rst_i), .load_i(mdLoad), .step_i(mdStep), .last_o(mdLast)
    );

    mulDivDatapath mdPath (
        .clk(clk), .rst_i(rst_i), .load_i(mdLoad), .step_i(mdStep), .commit_i(mdCommit),
        .op_i(mdOp), .a_i(mdA), .b_i(mdB), .hi_o(hi), .lo_o(lo)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
failMsg="Finished with errors"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pipeCore_tb -Mdir obj_dir -o simPipe -f tb.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simPipe > "$log" 2>&1
runStatus=$?
cat "$log"

if grep -q "$failMsg" "$log"; then
    echo "FAIL: fail message found in $log"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "FAIL: simulator exited with status $runStatus"
    exit 1
fi
echo "PASS"
exit 0

// File: sim/clockGen.sv
`default_nettype none

module clockGen #(
    parameter int PeriodNs = 40
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PeriodNs / 2) clk_o = ~clk_o;    // half period per toggle
        end
    end

endmodule

`default_nettype wire

// File: sim/pipeCore_sva.sv
`default_nettype none

module pipeCore_sva import mipsPkg::*; (
    input wire           clk,
    input wire           rst_i,
    input wire word_t    pcF_i,
    input wire           instEnF_i,
    input wire           mulDivBusy_i,
    input wire wbDebug_s debugWb_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // a debug write always names a real register
    noZeroWrite: assert property (@(posedge clk) disable iff (rst_i)
        (debugWb_i.wen != 4'h0) |-> (debugWb_i.wnum != 5'd0))
        else $error("debug write-back names register zero");

    // fetch is frozen for the whole mul/div stall
    noFetchWhileBusy: assert property (@(posedge clk) disable iff (rst_i)
        mulDivBusy_i |=> !$past(instEnF_i) && $stable(pcF_i))
        else $error("instruction fetch moved during a mul/div stall");

    pcAligned: assert property (@(posedge clk) disable iff (rst_i)
        pcF_i[1:0] == 2'b00)
        else $error("fetch pc not word aligned");

endmodule

bind pipeCore pipeCore_sva outputChecks (
    .clk(clk), .rst_i(rst_i), .pcF_i(pcF_o), .instEnF_i(instEnF_o),
    .mulDivBusy_i(mulDivBusy_o), .debugWb_i(debugWb_o)
);

`default_nettype wire

// File: sim/pipeCore_tb.sv
`default_nettype none

module pipeCore_tb import mipsPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t PcReset     = PcResetDefault;
    localparam int    WbTimeout   = 200;    // cycles, covers a whole mul/div stall
    localparam int    DrainCycles = 40;

    // MIPS opcode and funct codes
    localparam logic [5:0] OpAddiu = 6'h09;
    localparam logic [5:0] OpOri   = 6'h0D;
    localparam logic [5:0] OpLui   = 6'h0F;
    localparam logic [5:0] FnSll   = 6'h00;
    localparam logic [5:0] FnMfhi  = 6'h10;
    localparam logic [5:0] FnMflo  = 6'h12;
    localparam logic [5:0] FnMultu = 6'h19;
    localparam logic [5:0] FnDivu  = 6'h1B;
    localparam logic [5:0] FnAddu  = 6'h21;
    localparam logic [5:0] FnSubu  = 6'h23;
    localparam logic [5:0] FnAnd   = 6'h24;
    localparam logic [5:0] FnOr    = 6'h25;
    localparam logic [5:0] FnXor   = 6'h26;
    localparam logic [5:0] FnSlt   = 6'h2A;

    typedef struct packed {
        word_t   pc;
        regIdx_t wnum;
        word_t   wdata;
    } expWb_s;

    logic     clk;
    logic     rst = 1'b1;
    word_t    instrF = '0;
    word_t    pcF;
    logic     instEnF;
    logic     mdBusy;
    wbDebug_s debugWb;

    word_t       prog[$];      // program table, one word per pc slot
    expWb_s      expQ[$];      // expected write-backs in program order
    word_t       model[32];    // register state under sequential execution
    word_t       hiM;
    word_t       loM;
    logic [31:0] lfsr = 32'd95211;
    int          busyRises = 0;
    logic        busyPrev = 1'b0;

    clockGen #(.PeriodNs(40)) clkSrc (.clk_o(clk));

    pipeCore #(.PcReset(PcReset), .Iters(MulDivIters)) UUT (
        .clk(clk), .rst_i(rst), .instrF_i(instrF), .pcF_o(pcF), .instEnF_o(instEnF),
        .mulDivBusy_o(mdBusy), .debugWb_o(debugWb)
    );

    function automatic word_t romWord(word_t pc);
        int    idx;
        word_t w;
        idx = int'((pc - PcReset) >> 2);
        w = (idx < prog.size()) ? prog[idx] : '0;    // zero past the end
        return w;
    endfunction

    // synchronous rom, word appears one edge after the enable
    always @(posedge clk) begin
        if (instEnF) begin
            instrF <= romWord(pcF);
        end
    end

    always @(negedge clk) begin
        if (mdBusy && !busyPrev) begin
            busyRises++;
        end
        busyPrev = mdBusy;
    end

    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic randBits(int n, output word_t w);
        w = '0;
        for (int k = 0; k < n; k++) begin
            w = {w[Xlen-2:0], lfsr[0]};
            lfsr = lfsrStep(lfsr);
        end
    endtask

    task automatic failRun();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            failRun();
        end
    endtask

    task automatic rawWord(word_t w);
        prog.push_back(w);
    endtask

    // call after the instruction went into the table
    task automatic writeReg(regIdx_t rd, word_t val);
        word_t pc;
        pc = PcReset + word_t'(4 * (prog.size() - 1));
        if (rd != 5'd0) begin
            expQ.push_back('{pc: pc, wnum: rd, wdata: val});
            model[rd] = val;
        end
    endtask

    task automatic rOp(logic [5:0] fn, regIdx_t rd, regIdx_t rs, regIdx_t rt,
                       logic [4:0] sa);
        word_t a;
        word_t b;
        word_t res;
        a = model[rs];
        b = model[rt];
        case (fn)
            FnAddu:  res = a + b;
            FnSubu:  res = a - b;
            FnAnd:   res = a & b;
            FnOr:    res = a | b;
            FnXor:   res = a ^ b;
            FnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FnSll:   res = b << sa;
            FnMfhi:  res = hiM;
            FnMflo:  res = loM;
            default: res = '0;
        endcase
        prog.push_back({6'h00, rs, rt, rd, sa, fn});
        writeReg(rd, res);
    endtask

    task automatic iOp(logic [5:0] op, regIdx_t rt, regIdx_t rs, logic [15:0] imm);
        word_t res;
        case (op)
            OpAddiu: res = model[rs] + {{16{imm[15]}}, imm};
            OpOri:   res = model[rs] | {16'h0000, imm};
            OpLui:   res = {imm, 16'h0000};
            default: res = '0;
        endcase
        prog.push_back({op, rs, rt, imm});
        writeReg(rt, res);
    endtask

    task automatic mdOp(logic [5:0] fn, regIdx_t rs, regIdx_t rt);
        logic [63:0] prod;
        if (fn == FnMultu) begin
            prod = {32'h0, model[rs]} * {32'h0, model[rt]};
            hiM = prod[63:32];
            loM = prod[31:0];
        end else begin
            loM = model[rs] / model[rt];    // quotient
            hiM = model[rs] % model[rt];
        end
        prog.push_back({6'h00, rs, rt, 5'd0, 5'd0, fn});
    endtask

    task automatic loadConst(regIdx_t rd, word_t val);
        iOp(OpLui, rd, 5'd0, val[31:16]);
        iOp(OpOri, rd, rd, val[15:0]);    // distance one on rd
    endtask

    task automatic buildProgram();
        word_t opA;
        word_t opB;
        word_t divisor;
        randBits(32, opA);
        randBits(32, opB);
        randBits(16, divisor);
        if (divisor == '0) begin
            divisor = 32'd1;
        end
        loadConst(5'd1, opA);
        loadConst(5'd2, opB);
        rOp(FnAddu, 5'd3, 5'd1, 5'd2, 5'd0);
        rOp(FnSubu, 5'd4, 5'd3, 5'd1, 5'd0);
        rOp(FnAnd, 5'd5, 5'd4, 5'd3, 5'd0);     // distances one and two
        rOp(FnOr, 5'd6, 5'd5, 5'd1, 5'd0);
        rOp(FnXor, 5'd7, 5'd6, 5'd4, 5'd0);
        rOp(FnSlt, 5'd8, 5'd7, 5'd6, 5'd0);
        rOp(FnSlt, 5'd9, 5'd6, 5'd7, 5'd0);
        rOp(FnSll, 5'd10, 5'd0, 5'd7, 5'd5);
        iOp(OpAddiu, 5'd11, 5'd10, 16'h8001);   // negative immediate
        iOp(OpAddiu, 5'd12, 5'd0, 16'h7FF0);
        iOp(OpOri, 5'd13, 5'd0, 16'h8001);
        iOp(OpLui, 5'd14, 5'd0, 16'hA5C3);
        mdOp(FnMultu, 5'd1, 5'd2);
        rOp(FnMfhi, 5'd15, 5'd0, 5'd0, 5'd0);
        rOp(FnMflo, 5'd16, 5'd0, 5'd0, 5'd0);
        rOp(FnAddu, 5'd17, 5'd15, 5'd16, 5'd0);
        loadConst(5'd18, divisor);
        mdOp(FnDivu, 5'd1, 5'd18);
        rOp(FnMfhi, 5'd19, 5'd0, 5'd0, 5'd0);
        rOp(FnMflo, 5'd20, 5'd0, 5'd0, 5'd0);
        rOp(FnSubu, 5'd21, 5'd20, 5'd19, 5'd0);
        iOp(OpAddiu, 5'd0, 5'd1, 16'h1234);     // lands on $0
        rawWord({6'h23, 5'd1, 5'd5, 16'h0004});  // load word, not supported
        rawWord({6'h00, 5'd1, 5'd2, 5'd22, 5'd0, 6'h20});
        rOp(FnAddu, 5'd22, 5'd0, 5'd1, 5'd0);
        iOp(OpAddiu, 5'd23, 5'd0, 16'h0055);
        rOp(FnOr, 5'd24, 5'd0, 5'd0, 5'd0);
    endtask

    task automatic waitWriteBack(int n);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (debugWb.wen == 4'h0 && cnt < WbTimeout) begin
            @(negedge clk);
            cnt++;
        end
        if (debugWb.wen == 4'h0) begin
            $display("timed out after %0d cycles waiting for write-back %0d", WbTimeout, n);
            failRun();
        end
    endtask

    initial begin
        expWb_s e;
        for (int k = 0; k < 32; k++) begin
            model[k] = '0;
        end
        hiM = '0;
        loM = '0;
        buildProgram();

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkEq(pcF, PcReset, "pcF after reset");
        checkEq(word_t'(instEnF), '0, "instEnF after reset");
        checkEq(word_t'(debugWb.wen), '0, "wen after reset");

        for (int i = 0; i < expQ.size(); i++) begin
            e = expQ[i];
            waitWriteBack(i);
            checkEq(word_t'(debugWb.wen), 32'h0000_000F,
                    $sformatf("wen of write-back %0d", i));
            checkEq(debugWb.pc, e.pc, $sformatf("pc of write-back %0d", i));
            checkEq(word_t'(debugWb.wnum), word_t'(e.wnum),
                    $sformatf("wnum of write-back %0d", i));
            checkEq(debugWb.wdata, e.wdata, $sformatf("wdata of write-back %0d", i));
        end

        // tail of the program is zero words, so nothing else may write
        for (int k = 0; k < DrainCycles; k++) begin
            @(negedge clk);
            checkEq(word_t'(debugWb.wen), '0, "wen after the last expected write");
        end
        checkEq(word_t'(busyRises), 32'd2, "mul/div busy periods");

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/mulDivFsm.sv
logic/iterCounter.sv
logic/mulDivDatapath.sv
logic/pipeCore.sv
sim/clockGen.sv
sim/pipeCore_sva.sv
sim/pipeCore_tb.sv
